// File: timer_subsys.f
source/timer_width_pkg.sv
source/timer_mode_pkg.sv
source/tick_prescaler.sv
source/down_counter.sv
source/pwm_compare.sv
source/timer_ctrl.sv
source/timer_subsys.sv
tests/timer_subsys_tb.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = timer_subsys_tb
FILELIST = timer_subsys.f
PASS_MSG = TEST RESULT: PASS

.PHONY: sim clean

# build, run, and decide on the printed result
sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: tests/timer_subsys_tb.sv
`timescale 1ns/10ps

module timer_subsys_tb
    import timer_width_pkg::*;
    import timer_mode_pkg::*;
;

    localparam int max_ticks   = 80;     // all tests together, with room
    localparam int max_presc   = 3;
    localparam int cycle_limit = max_ticks * max_presc + 100;

    logic   pre_clk;
    logic   rst_n;
    mode_t  mode;
    presc_t prescaler;
    count_t reload_val;
    count_t compare_val;
    logic   start;
    logic   timeout;
    logic   pwm_out;
    count_t current_count;

    // reference model state, updated once per tick
    presc_t phase;
    int     tick_cnt;
    int     cycle_cnt = 0;
    count_t exp_count;
    logic   exp_timeout;
    logic   exp_pwm;
    mode_t  prev_mode;
    logic   prev_start;

    timer_subsys timer_subsys_inst (
        .pre_clk       (pre_clk),
        .rst_n         (rst_n),
        .mode          (mode),
        .prescaler     (prescaler),
        .reload_val    (reload_val),
        .compare_val   (compare_val),
        .start         (start),
        .timeout       (timeout),
        .pwm_out       (pwm_out),
        .current_count (current_count)
    );

    initial begin
        pre_clk = 1'b0;
        forever #50 pre_clk = ~pre_clk;
    end

    task automatic check_value(input string name, input count_t actual, input count_t expected);
        if (actual !== expected) begin
            $display("Error: time %0t, %s: got %0d, expected %0d", $time, name, actual, expected);
            $display("TEST RESULT: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // returns at the falling edge after the n-th following tick took effect
    task automatic wait_ticks(input int n);
        int target;
        target = tick_cnt + n;
        do begin
            @(negedge pre_clk);
        end while (tick_cnt < target);
    endtask

    // outputs are checked against the model on every falling edge
    always @(negedge pre_clk) begin : ref_model
        count_t nxt;
        presc_t last;
        if (!rst_n) begin
            phase       <= '0;
            tick_cnt    <= 0;
            exp_count   <= '0;
            exp_timeout <= 1'b0;
            exp_pwm     <= 1'b0;
            prev_mode   <= mode_off;
            prev_start  <= 1'b0;
        end else begin
            check_value("current_count", current_count, exp_count);
            check_value("timeout", count_t'(timeout), count_t'(exp_timeout));
            check_value("pwm_out", count_t'(pwm_out), count_t'(exp_pwm));
            last = (prescaler == '0) ? '0 : prescaler - presc_t'(1);   // zero acts as one
            if (phase < last) begin
                phase <= phase + presc_t'(1);
            end else begin
                phase      <= '0;                   // this cycle is a tick
                tick_cnt   <= tick_cnt + 1;
                prev_mode  <= mode;
                prev_start <= start;
                nxt = (exp_count == '0) ? reload_val : exp_count - count_t'(1);
                if (mode == mode_off) begin
                    exp_count   <= '0;
                    exp_timeout <= 1'b0;
                    exp_pwm     <= 1'b0;
                end else if (mode != prev_mode || (start && !prev_start)) begin
                    exp_count   <= reload_val;
                    exp_timeout <= 1'b0;
                    exp_pwm     <= 1'b0;
                end else if (mode == mode_oneshot) begin
                    if (exp_count != '0) begin
                        exp_count <= nxt;
                    end else begin
                        exp_timeout <= 1'b1;        // sticky until a reload
                    end
                end else begin
                    exp_count   <= nxt;             // periodic and pwm wrap alike
                    exp_timeout <= (exp_count == '0);
                    exp_pwm     <= (mode == mode_pwm) && (nxt >= compare_val);
                end
            end
        end
    end

    always @(posedge pre_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Simulation timed out after %0d cycles without finishing", cycle_cnt);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    task automatic oneshot_test();
        int r;
        int i;
        r = 4 + ($urandom % 6);
        @(posedge pre_clk);
        mode       <= mode_oneshot;
        reload_val <= count_t'(r);
        start      <= 1'b0;
        wait_ticks(1);                              // mode change reloads
        check_value("current_count", current_count, count_t'(r));
        @(posedge pre_clk);
        start <= 1'b1;
        wait_ticks(1);
        check_value("current_count", current_count, count_t'(r));
        for (i = r - 1; i >= 0; i--) begin
            wait_ticks(1);
            check_value("current_count", current_count, count_t'(i));
            check_value("timeout", count_t'(timeout), count_t'(0));
        end
        repeat (4) begin
            wait_ticks(1);                          // first zero tick, then held
            check_value("timeout", count_t'(timeout), count_t'(1));
            check_value("current_count", current_count, count_t'(0));
        end
    endtask

    task automatic periodic_test();
        int r;
        int j;
        int m;
        r = 2 + ($urandom % 5);
        @(posedge pre_clk);
        prescaler  <= presc_t'(1);
        mode       <= mode_periodic;
        reload_val <= count_t'(r);
        start      <= 1'b0;
        wait_ticks(1);
        check_value("current_count", current_count, count_t'(r));
        for (j = 1; j <= 2 * (r + 1); j++) begin
            wait_ticks(1);
            m = j % (r + 1);                        // position within the period
            check_value("current_count", current_count, count_t'((m == 0) ? r : r - m));
            check_value("timeout", count_t'(timeout), count_t'(m == 0));
        end
    endtask

    task automatic pwm_test();
        int r;
        int c;
        int prev;
        int nxt;
        int highs;
        r = 3 + ($urandom % 6);
        c = 1 + ($urandom % r);                     // compare never above reload
        @(posedge pre_clk);
        mode        <= mode_pwm;
        reload_val  <= count_t'(r);
        compare_val <= count_t'(c);
        wait_ticks(1);
        check_value("current_count", current_count, count_t'(r));
        check_value("pwm_out", count_t'(pwm_out), count_t'(0));
        prev  = r;
        highs = 0;
        repeat (r + 1) begin
            nxt = (prev == 0) ? r : prev - 1;
            wait_ticks(1);
            check_value("current_count", current_count, count_t'(nxt));
            check_value("pwm_out", count_t'(pwm_out), count_t'(nxt >= c));
            if (pwm_out) begin
                highs++;
            end
            prev = nxt;
        end
        check_value("pwm high ticks", count_t'(highs), count_t'(r - c + 1));
    endtask

    task automatic restart_test();
        int r;
        r = 8 + ($urandom % 5);
        @(posedge pre_clk);
        mode       <= mode_oneshot;
        reload_val <= count_t'(r);
        start      <= 1'b1;
        wait_ticks(1);
        check_value("current_count", current_count, count_t'(r));
        wait_ticks(3);
        check_value("current_count", current_count, count_t'(r - 3));
        @(posedge pre_clk);
        start <= 1'b0;                              // low for one tick
        wait_ticks(1);
        check_value("count below reload", count_t'(current_count < count_t'(r)), count_t'(1));
        @(posedge pre_clk);
        start <= 1'b1;
        wait_ticks(1);
        check_value("current_count", current_count, count_t'(r));
        wait_ticks(2);                              // held high, no new edge
        check_value("current_count", current_count, count_t'(r - 2));
    endtask

    task automatic mode_change_test();
        int r;
        r = 3 + ($urandom % 4);
        @(posedge pre_clk);
        mode       <= mode_periodic;
        reload_val <= count_t'(r);
        wait_ticks(1);
        check_value("current_count", current_count, count_t'(r));
        wait_ticks(2);
        check_value("current_count", current_count, count_t'(r - 2));
        @(posedge pre_clk);
        mode <= mode_pwm;
        wait_ticks(1);
        check_value("current_count", current_count, count_t'(r));
        check_value("timeout", count_t'(timeout), count_t'(0));
        check_value("pwm_out", count_t'(pwm_out), count_t'(0));
        @(posedge pre_clk);
        mode <= mode_off;
        repeat (5) begin
            wait_ticks(1);
            check_value("current_count", current_count, count_t'(0));
            check_value("timeout", count_t'(timeout), count_t'(0));
            check_value("pwm_out", count_t'(pwm_out), count_t'(0));
        end
    endtask

    initial begin
        void'($urandom(32'h0efb9dbe));
        rst_n       <= 1'b0;
        mode        <= mode_off;
        prescaler   <= presc_t'(3);
        reload_val  <= '0;
        compare_val <= '0;
        start       <= 1'b0;
        repeat (5) @(posedge pre_clk);
        rst_n <= 1'b1;
        oneshot_test();
        periodic_test();
        pwm_test();
        restart_test();
        mode_change_test();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: source/timer_subsys.sv
`timescale 1ns/10ps

module timer_subsys
    import timer_width_pkg::*;
    import timer_mode_pkg::*;
#(
    parameter int cnt_w = timer_width_pkg::cnt_w
) (
    input  logic             pre_clk,
    input  logic             rst_n,
    input  mode_t            mode,
    input  presc_t           prescaler,
    input  logic [cnt_w-1:0] reload_val,
    input  logic [cnt_w-1:0] compare_val,
    input  logic             start,
    output logic             timeout,
    output logic             pwm_out,
    output logic [cnt_w-1:0] current_count
);

    logic             tick;         // one pre_clk cycle per prescaler period
    logic             load;
    logic             load_zero;
    logic             dec;
    logic             count_zero;
    logic [cnt_w-1:0] next_count;
    logic             pwm_update;
    logic             pwm_clear;

    tick_prescaler tick_prescaler_inst (
        .pre_clk   (pre_clk),
        .rst_n     (rst_n),
        .prescaler (prescaler),
        .tick      (tick)
    );

    timer_ctrl #(
        .cnt_w (cnt_w)
    ) timer_ctrl_inst (
        .pre_clk    (pre_clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .mode       (mode),
        .start      (start),
        .count_zero (count_zero),
        .load       (load),
        .load_zero  (load_zero),
        .dec        (dec),
        .pwm_update (pwm_update),
        .pwm_clear  (pwm_clear),
        .timeout    (timeout)
    );

    down_counter #(
        .cnt_w (cnt_w)
    ) down_counter_inst (
        .pre_clk    (pre_clk),
        .rst_n      (rst_n),
        .load       (load),
        .load_zero  (load_zero),
        .dec        (dec),
        .reload_val (reload_val),
        .count      (current_count),
        .next_count (next_count),
        .count_zero (count_zero)
    );

    pwm_compare #(
        .cnt_w (cnt_w)
    ) pwm_compare_inst (
        .pre_clk     (pre_clk),
        .rst_n       (rst_n),
        .pwm_update  (pwm_update),
        .pwm_clear   (pwm_clear),
        .next_count  (next_count),
        .compare_val (compare_val),
        .pwm_out     (pwm_out)
    );

endmodule

// File: source/timer_ctrl.sv
`timescale 1ns/10ps

module timer_ctrl
    import timer_mode_pkg::*;
#(
    parameter int cnt_w = timer_width_pkg::cnt_w
) (
    input  logic  pre_clk,
    input  logic  rst_n,
    input  logic  tick,
    input  mode_t mode,
    input  logic  start,
    input  logic  count_zero,
    output logic  load,
    output logic  load_zero,
    output logic  dec,
    output logic  pwm_update,
    output logic  pwm_clear,
    output logic  timeout
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    mode_t       mode_q;        // mode seen at the previous tick
    logic        start_q;       // start sampled at the previous tick
    logic        reload_ev;
    logic        timeout_nxt;

    // the counter needs at least one bit to hold a reload value
    if (cnt_w < 1) begin : g_width_check
        $error("timer_ctrl: cnt_w must be at least 1");
    end

    assign reload_ev = (mode != mode_q) || (start && !start_q);

    always_comb begin
        load        = 1'b0;
        load_zero   = 1'b0;
        dec         = 1'b0;
        pwm_update  = 1'b0;
        pwm_clear   = 1'b0;
        state_nxt   = state;
        timeout_nxt = timeout;

        if (tick) begin
            if (mode == mode_off) begin
                // disabled wins over any reload event
                load        = 1'b1;
                load_zero   = 1'b1;
                pwm_clear   = 1'b1;
                timeout_nxt = 1'b0;
                state_nxt   = st_idle;
            end else if (reload_ev) begin
                load        = 1'b1;
                pwm_clear   = 1'b1;     // low until the first compare
                timeout_nxt = 1'b0;
                state_nxt   = st_run;
            end else begin
                unique case (state)
                    st_run: begin
                        if (!count_zero) begin
                            dec         = 1'b1;
                            timeout_nxt = 1'b0;     // ends the periodic pulse
                        end else if (mode == mode_oneshot) begin
                            timeout_nxt = 1'b1;
                            state_nxt   = st_done;
                        end else begin
                            load        = 1'b1;     // periodic and pwm wrap
                            timeout_nxt = 1'b1;
                        end
                        pwm_update = (mode == mode_pwm);
                        pwm_clear  = (mode != mode_pwm);
                    end
                    st_done: begin
                        timeout_nxt = 1'b1;         // sticky until a reload
                        pwm_clear   = 1'b1;
                    end
                    default: begin
                        // idle with a live mode, restart the count
                        load        = 1'b1;
                        pwm_clear   = 1'b1;
                        timeout_nxt = 1'b0;
                        state_nxt   = st_run;
                    end
                endcase
            end
        end
    end

    always_ff @(posedge pre_clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= st_idle;
            mode_q  <= mode_off;
            start_q <= 1'b0;
            timeout <= 1'b0;
        end else if (tick) begin
            state   <= state_nxt;
            mode_q  <= mode;
            start_q <= start;
            timeout <= timeout_nxt;
        end
    end

    // counter strobes are exclusive and only ever issued on a tick
    a_strobe_excl: assert property (
        @(posedge pre_clk) disable iff (!rst_n) !(load && dec)
    ) else $error("timer_ctrl: load and dec together");

    a_strobe_on_tick: assert property (
        @(posedge pre_clk) disable iff (!rst_n) (load || dec) |-> tick
    ) else $error("timer_ctrl: counter strobe without tick");

endmodule

// File: source/pwm_compare.sv
`timescale 1ns/10ps

module pwm_compare #(
    parameter int cnt_w = timer_width_pkg::cnt_w
) (
    input  logic             pre_clk,
    input  logic             rst_n,
    input  logic             pwm_update,
    input  logic             pwm_clear,
    input  logic [cnt_w-1:0] next_count,
    input  logic [cnt_w-1:0] compare_val,
    output logic             pwm_out
);

    logic at_or_above;      // the single comparator

    assign at_or_above = (next_count >= compare_val);

    always_ff @(posedge pre_clk or negedge rst_n) begin
        if (!rst_n) begin
            pwm_out <= 1'b0;
        end else if (pwm_clear) begin
            pwm_out <= 1'b0;
        end else if (pwm_update) begin
            pwm_out <= at_or_above;
        end
    end

endmodule

// File: source/down_counter.sv
`timescale 1ns/10ps

module down_counter #(
    parameter int cnt_w = timer_width_pkg::cnt_w
) (
    input  logic             pre_clk,
    input  logic             rst_n,
    input  logic             load,
    input  logic             load_zero,
    input  logic             dec,
    input  logic [cnt_w-1:0] reload_val,
    output logic [cnt_w-1:0] count,
    output logic [cnt_w-1:0] next_count,
    output logic             count_zero
);

    // only zero test in the design
    assign count_zero = (count == '0);

    // value after a decrement step, wrapping to the reload value at zero
    assign next_count = count_zero ? reload_val : count - cnt_w'(1);

    always_ff @(posedge pre_clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (load) begin
            count <= load_zero ? '0 : reload_val;   // load has priority
        end else if (dec) begin
            count <= count - cnt_w'(1);
        end
    end

    // decrement is only asked for a nonzero count
    a_no_underflow: assert property (
        @(posedge pre_clk) disable iff (!rst_n) (dec && !load) |-> !count_zero
    ) else $error("down_counter: decrement at zero");

endmodule

// File: source/tick_prescaler.sv
`timescale 1ns/10ps

module tick_prescaler
    import timer_width_pkg::*;
(
    input  logic   pre_clk,
    input  logic   rst_n,
    input  presc_t prescaler,
    output logic   tick
);

    presc_t presc_cnt;      // position inside the tick period
    presc_t presc_last;     // wrap value

    // zero behaves as one, so the tick is then high every cycle
    assign presc_last = (prescaler == '0) ? '0 : presc_t'(prescaler - presc_t'(1));

    // >= so a smaller prescaler written mid-period wraps at once
    assign tick = (presc_cnt >= presc_last);

    always_ff @(posedge pre_clk or negedge rst_n) begin
        if (!rst_n) begin
            presc_cnt <= '0;
        end else if (tick) begin
            presc_cnt <= '0;
        end else begin
            presc_cnt <= presc_cnt + presc_t'(1);
        end
    end

    // with a stable divide ratio above one, ticks are isolated pulses
    a_tick_isolated: assert property (
        @(posedge pre_clk) disable iff (!rst_n)
        (tick && prescaler > presc_t'(1)) |=> (!tick || prescaler != $past(prescaler))
    ) else $error("tick_prescaler: back-to-back ticks at prescaler %0d", prescaler);

endmodule

// File: source/timer_mode_pkg.sv
package timer_mode_pkg;

    typedef logic [1:0] mode_t;

    localparam mode_t mode_off      = 2'b00;    // count held at zero
    localparam mode_t mode_oneshot  = 2'b01;    // count down once, sticky timeout
    localparam mode_t mode_periodic = 2'b10;    // count down and reload
    localparam mode_t mode_pwm      = 2'b11;    // periodic plus compare output

    // control FSM states
    typedef enum logic [1:0] {
        st_idle = 2'b00,    // disabled
        st_run  = 2'b01,    // counting
        st_done = 2'b10     // one-shot expired
    } ctrl_state_t;

endpackage

// File: source/timer_width_pkg.sv
package timer_width_pkg;

    // default counter width, overridable at the top level
    localparam int cnt_w = 32;

    // prescaler width is fixed
    localparam int presc_w = 16;

    // pre_clk cycles per tick
    typedef logic [presc_w-1:0] presc_t;

    // count at the default width
    typedef logic [cnt_w-1:0] count_t;

endpackage
